//--- logic/rv32_isa_pkg.sv
package rv32_isa_pkg;

    localparam int unsigned xlen = 32;
    // instruction length in bytes
    localparam int unsigned inst_len = 4;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    // instruction bits 6:2
    typedef enum logic [4:0] {
        opc_load    = 5'b00000,
        opc_miscmem = 5'b00011,
        opc_opimm   = 5'b00100,
        opc_auipc   = 5'b00101,
        opc_store   = 5'b01000,
        opc_op      = 5'b01100,
        opc_lui     = 5'b01101,
        opc_branch  = 5'b11000,
        opc_jalr    = 5'b11001,
        opc_jal     = 5'b11011,
        opc_system  = 5'b11100
    } opcode_e;

    // encoded as {funct7 bit 5, funct3}
    typedef enum logic [3:0] {
        alu_add  = 4'b0000,
        alu_sll  = 4'b0001,
        alu_slt  = 4'b0010,
        alu_sltu = 4'b0011,
        alu_xor  = 4'b0100,
        alu_srl  = 4'b0101,
        alu_or   = 4'b0110,
        alu_and  = 4'b0111,
        alu_sub  = 4'b1000,
        alu_sra  = 4'b1101
    } alu_op_e;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        opcode_e    opcode;
        logic [1:0] quadrant;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        opcode_e     opcode;
        logic [1:0]  quadrant;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
        logic [1:0] quadrant;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        opcode_e    opcode;
        logic [1:0] quadrant;
    } b_fmt_t;

    // also carries the jal immediate, scrambled
    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        opcode_e     opcode;
        logic [1:0]  quadrant;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
    } instr_u;

    typedef struct packed {
        reg_idx_t             rs1;
        reg_idx_t             rs2;
        reg_idx_t             rd;
        word_t                imm;
        opcode_e              opcode;
        logic [2:0]           funct3;
        alu_op_e              alu_op;
        // {geu, ltu, ge, lt, ne, eq}
        logic [5:0]           branch_mask;
        wb8_bus_pkg::bus_op_e bus_op;
    } decoded_t;

endpackage

//--- logic/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
    input  rv32_isa_pkg::word_t   a,
    input  rv32_isa_pkg::word_t   b,
    input  rv32_isa_pkg::alu_op_e op,
    output rv32_isa_pkg::word_t   result,
    output logic                  lt,
    output logic                  ltu,
    output logic                  eq
);
    import rv32_isa_pkg::*;

    logic [4:0] shamt;

    assign shamt = b[4:0];

    // compare flags, also used by the branch logic
    assign lt  = $signed(a) < $signed(b);
    assign ltu = a < b;
    assign eq  = a == b;

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {{(xlen-1){1'b0}}, lt};
            alu_sltu: result = {{(xlen-1){1'b0}}, ltu};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $signed(a) >>> shamt;
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = a + b;
        endcase
    end

endmodule

//--- logic/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   en,
    input  rv32_isa_pkg::word_t    instr,
    output rv32_isa_pkg::decoded_t dec
);
    import rv32_isa_pkg::*;
    import wb8_bus_pkg::*;

    instr_u   iw;
    decoded_t dec_d;
    logic     alt;

    assign iw = instr;

    // funct7 bit 5 selects sub and sra, but only srai in the immediate form
    assign alt = iw.r_fmt.funct7[5]
               & (iw.r_fmt.opcode == opc_op || iw.r_fmt.funct3 == 3'b101);

    always_comb begin
        dec_d        = '0;
        dec_d.rs1    = iw.r_fmt.rs1;
        dec_d.rs2    = iw.r_fmt.rs2;
        dec_d.rd     = iw.r_fmt.rd;
        dec_d.opcode = iw.r_fmt.opcode;
        dec_d.funct3 = iw.r_fmt.funct3;
        dec_d.alu_op = alu_op_e'({alt, iw.r_fmt.funct3});

        // immediate by format
        case (iw.r_fmt.opcode)
            opc_store:
                dec_d.imm = {{20{iw.s_fmt.imm_hi[6]}}, iw.s_fmt.imm_hi, iw.s_fmt.imm_lo};
            opc_branch:
                dec_d.imm = {{20{iw.b_fmt.imm12}}, iw.b_fmt.imm11, iw.b_fmt.imm10_5,
                             iw.b_fmt.imm4_1, 1'b0};
            opc_lui, opc_auipc:
                dec_d.imm = {iw.u_fmt.imm, 12'b0};
            opc_jal:
                dec_d.imm = {{11{iw.u_fmt.imm[19]}}, iw.u_fmt.imm[19], iw.u_fmt.imm[7:0],
                             iw.u_fmt.imm[8], iw.u_fmt.imm[18:9], 1'b0};
            default:
                dec_d.imm = {{20{iw.i_fmt.imm[11]}}, iw.i_fmt.imm};
        endcase

        case (iw.r_fmt.funct3)
            3'b000:  dec_d.branch_mask = 6'b000001;
            3'b001:  dec_d.branch_mask = 6'b000010;
            3'b100:  dec_d.branch_mask = 6'b000100;
            3'b101:  dec_d.branch_mask = 6'b001000;
            3'b110:  dec_d.branch_mask = 6'b010000;
            3'b111:  dec_d.branch_mask = 6'b100000;
            default: dec_d.branch_mask = 6'b000000;
        endcase

        // load and store size from funct3
        if (iw.r_fmt.opcode == opc_store) begin
            case (iw.r_fmt.funct3)
                3'b000:  dec_d.bus_op = write_b;
                3'b001:  dec_d.bus_op = write_h;
                default: dec_d.bus_op = write_w;
            endcase
        end else begin
            case (iw.r_fmt.funct3)
                3'b000:  dec_d.bus_op = read_b;
                3'b001:  dec_d.bus_op = read_h;
                3'b100:  dec_d.bus_op = read_bu;
                3'b101:  dec_d.bus_op = read_hu;
                default: dec_d.bus_op = read_w;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            dec <= '0;
        end else if (en) begin
            dec <= dec_d;
        end
    end

endmodule

//--- logic/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
    input  logic                   clk,
    input  rv32_isa_pkg::reg_idx_t rs1,
    input  rv32_isa_pkg::reg_idx_t rs2,
    input  rv32_isa_pkg::reg_idx_t rd,
    input  logic                   we,
    input  rv32_isa_pkg::word_t    wdata,
    output rv32_isa_pkg::word_t    rdata1,
    output rv32_isa_pkg::word_t    rdata2
);
    import rv32_isa_pkg::*;

    // x0 has no storage
    word_t regs [1:31];

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

endmodule

//--- logic/rv_sequencer.sv
`timescale 1ns/1ps

module rv_sequencer #(
    parameter rv32_isa_pkg::word_t reset_vector = '0
) (
    input  logic                   clk,
    input  logic                   reset,
    input  rv32_isa_pkg::decoded_t dec,
    input  rv32_isa_pkg::word_t    rdata1,
    input  rv32_isa_pkg::word_t    rdata2,
    output logic                   dec_en,
    output logic                   rf_we,
    output rv32_isa_pkg::word_t    rf_wdata,
    output wb8_bus_pkg::bus_req_t  bus_req,
    input  wb8_bus_pkg::bus_rsp_t  bus_rsp
);
    import rv32_isa_pkg::*;
    import wb8_bus_pkg::*;

    typedef enum logic [2:0] {st_fetch, st_decode, st_exec, st_mem, st_branch} state_e;
    typedef enum logic [1:0] {wb_alu, wb_bus, wb_imm} wb_sel_e;

    state_e  state;
    wb_sel_e wb_sel;
    word_t   pc;
    word_t   pc_next;
    word_t   result_q;
    logic    req_sent;
    logic    wb_pending;
    logic    take_q;

    word_t   alu_a;
    word_t   alu_b;
    word_t   alu_result;
    alu_op_e alu_op;
    logic    alu_lt;
    logic    alu_ltu;
    logic    alu_eq;
    logic    taken;

    rv_alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .lt     (alu_lt),
        .ltu    (alu_ltu),
        .eq     (alu_eq)
    );

    assign taken = |(dec.branch_mask & {~alu_ltu, alu_ltu, ~alu_lt, alu_lt, ~alu_eq, alu_eq});

    always_comb begin
        alu_a  = rdata1;
        alu_b  = rdata2;
        alu_op = alu_add;
        case (state)
            st_decode: begin
                // ALU is idle, so compute pc + 4 here
                alu_a = pc;
                alu_b = word_t'(inst_len);
            end
            st_exec: begin
                case (dec.opcode)
                    opc_op: begin
                        alu_op = dec.alu_op;
                    end
                    opc_opimm: begin
                        alu_b  = dec.imm;
                        alu_op = dec.alu_op;
                    end
                    opc_load, opc_store, opc_jalr: begin
                        alu_b = dec.imm;
                    end
                    opc_jal, opc_auipc: begin
                        alu_a = pc;
                        alu_b = dec.imm;
                    end
                    default: begin
                        // branch compares rs1 with rs2
                        alu_op = alu_add;
                    end
                endcase
            end
            st_branch: begin
                alu_a = pc;
                alu_b = dec.imm;
            end
            default: begin
                alu_op = alu_add;
            end
        endcase
    end

    assign dec_en = state == st_decode;

    // result of the previous instruction goes back in the first fetch cycle
    assign rf_we = state == st_fetch && !req_sent && wb_pending;

    always_comb begin
        case (wb_sel)
            wb_alu:  rf_wdata = result_q;
            wb_bus:  rf_wdata = bus_rsp.rdata;
            default: rf_wdata = dec.imm;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= st_fetch;
            pc_next       <= reset_vector;
            req_sent      <= 1'b0;
            wb_pending    <= 1'b0;
            bus_req.start <= 1'b0;
        end else begin
            bus_req.start <= 1'b0;
            case (state)
                st_fetch: begin
                    if (!req_sent) begin
                        wb_pending      <= 1'b0;
                        pc              <= pc_next;
                        bus_req.start   <= 1'b1;
                        bus_req.op      <= read_w;
                        bus_req.address <= pc_next;
                        req_sent        <= 1'b1;
                    end else if (bus_rsp.done) begin
                        req_sent <= 1'b0;
                        state    <= st_decode;
                    end
                end
                st_decode: begin
                    pc_next <= alu_result;
                    state   <= st_exec;
                end
                st_exec: begin
                    result_q <= alu_result;
                    state    <= st_fetch;
                    case (dec.opcode)
                        opc_op, opc_opimm, opc_auipc: begin
                            wb_pending <= 1'b1;
                            wb_sel     <= wb_alu;
                        end
                        opc_lui: begin
                            wb_pending <= 1'b1;
                            wb_sel     <= wb_imm;
                        end
                        opc_jal, opc_jalr: begin
                            // link is pc + 4 from decode
                            result_q   <= pc_next;
                            pc_next    <= {alu_result[31:1], 1'b0};
                            wb_pending <= 1'b1;
                            wb_sel     <= wb_alu;
                        end
                        opc_load: begin
                            wb_pending <= 1'b1;
                            wb_sel     <= wb_bus;
                            state      <= st_mem;
                        end
                        opc_store: begin
                            state <= st_mem;
                        end
                        opc_branch: begin
                            take_q <= taken;
                            state  <= st_branch;
                        end
                        default: begin
                            // miscmem, system and unknown fall through
                            state <= st_fetch;
                        end
                    endcase
                end
                st_mem: begin
                    if (!req_sent) begin
                        bus_req.start   <= 1'b1;
                        bus_req.op      <= dec.bus_op;
                        bus_req.address <= result_q;
                        bus_req.wdata   <= rdata2;
                        req_sent        <= 1'b1;
                    end else if (bus_rsp.done) begin
                        req_sent <= 1'b0;
                        state    <= st_fetch;
                    end
                end
                default: begin
                    // branch target pc + imm
                    if (take_q) begin
                        pc_next <= alu_result;
                    end
                    state <= st_fetch;
                end
            endcase
        end
    end

endmodule

//--- logic/spu32_core.sv
`timescale 1ns/1ps

module spu32_core #(
    parameter rv32_isa_pkg::word_t reset_vector = '0
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                ack,
    input  logic                stall,
    input  logic [7:0]          rdata,
    output rv32_isa_pkg::word_t adr,
    output logic [7:0]          wdata,
    output logic                cyc,
    output logic                stb,
    output logic                we
);
    import rv32_isa_pkg::*;
    import wb8_bus_pkg::*;

    decoded_t dec;
    word_t    rdata1;
    word_t    rdata2;
    word_t    rf_wdata;
    logic     dec_en;
    logic     rf_we;
    bus_req_t bus_req;
    bus_rsp_t bus_rsp;

    // fetched words are decoded straight off the bus response
    rv_decoder u_decoder (
        .clk   (clk),
        .reset (reset),
        .en    (dec_en),
        .instr (bus_rsp.rdata),
        .dec   (dec)
    );

    rv_regfile u_regfile (
        .clk    (clk),
        .rs1    (dec.rs1),
        .rs2    (dec.rs2),
        .rd     (dec.rd),
        .we     (rf_we),
        .wdata  (rf_wdata),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    wb8_byte_master u_bus (
        .clk   (clk),
        .reset (reset),
        .req   (bus_req),
        .rsp   (bus_rsp),
        .ack   (ack),
        .stall (stall),
        .rdata (rdata),
        .adr   (adr),
        .wdata (wdata),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we)
    );

    rv_sequencer #(
        .reset_vector (reset_vector)
    ) u_sequencer (
        .clk      (clk),
        .reset    (reset),
        .dec      (dec),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .dec_en   (dec_en),
        .rf_we    (rf_we),
        .rf_wdata (rf_wdata),
        .bus_req  (bus_req),
        .bus_rsp  (bus_rsp)
    );

endmodule

//--- logic/wb8_bus_pkg.sv
package wb8_bus_pkg;

    // access size and direction, writes sit at the top of the encoding
    typedef enum logic [2:0] {
        read_b  = 3'd0,
        read_h  = 3'd1,
        read_w  = 3'd2,
        read_bu = 3'd3,
        read_hu = 3'd4,
        write_b = 3'd5,
        write_h = 3'd6,
        write_w = 3'd7
    } bus_op_e;

    typedef struct packed {
        logic        start;
        bus_op_e     op;
        logic [31:0] address;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        done;
        logic [31:0] rdata;
    } bus_rsp_t;

    function automatic logic is_write(bus_op_e op);
        return op >= write_b;
    endfunction

endpackage

//--- logic/wb8_byte_master.sv
`timescale 1ns/1ps

module wb8_byte_master (
    input  logic                  clk,
    input  logic                  reset,
    input  wb8_bus_pkg::bus_req_t req,
    output wb8_bus_pkg::bus_rsp_t rsp,
    input  logic                  ack,
    input  logic                  stall,
    input  logic [7:0]            rdata,
    output rv32_isa_pkg::word_t   adr,
    output logic [7:0]            wdata,
    output logic                  cyc,
    output logic                  stb,
    output logic                  we
);
    import rv32_isa_pkg::*;
    import wb8_bus_pkg::*;

    bus_op_e    op;
    word_t      shift;
    logic [1:0] remaining;
    logic       done;
    logic       byte_acked;

    // bytes after the first one
    function automatic logic [1:0] extra_bytes(bus_op_e o);
        case (o)
            read_w, write_w:          return 2'd3;
            read_h, read_hu, write_h: return 2'd1;
            default:                  return 2'd0;
        endcase
    endfunction

    // the ack that closes an accepted byte
    assign byte_acked = cyc && !stb && ack;

    // store data leaves from the bottom of the shift register
    assign wdata = shift[7:0];

    always_ff @(posedge clk) begin
        if (reset) begin
            cyc       <= 1'b0;
            stb       <= 1'b0;
            we        <= 1'b0;
            done      <= 1'b0;
            remaining <= 2'd0;
        end else begin
            done <= 1'b0;
            if (req.start) begin
                cyc       <= 1'b1;
                stb       <= 1'b1;
                we        <= is_write(req.op);
                remaining <= extra_bytes(req.op);
            end else if (stb) begin
                // byte accepted once stall drops
                if (!stall) begin
                    stb <= 1'b0;
                end
            end else if (byte_acked) begin
                if (remaining == 2'd0) begin
                    cyc  <= 1'b0;
                    we   <= 1'b0;
                    done <= 1'b1;
                end else begin
                    remaining <= remaining - 2'd1;
                    stb       <= 1'b1;
                end
            end
        end
    end

    // address and data, lsb first
    always_ff @(posedge clk) begin
        if (req.start) begin
            op    <= req.op;
            adr   <= req.address;
            shift <= req.wdata;
        end else if (byte_acked) begin
            shift <= {rdata, shift[31:8]};
            adr   <= adr + 1'b1;
        end
    end

    // loaded bytes end up at the top of the shift register
    always_comb begin
        rsp.done = done;
        case (op)
            read_b:  rsp.rdata = {{24{shift[31]}}, shift[31:24]};
            read_bu: rsp.rdata = {24'b0, shift[31:24]};
            read_h:  rsp.rdata = {{16{shift[31]}}, shift[31:16]};
            read_hu: rsp.rdata = {16'b0, shift[31:16]};
            default: rsp.rdata = shift;
        endcase
    end

endmodule

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module spu32_core_tb \
    -f spu32_core.f --Mdir obj_dir -o spu32_sim > build.log 2>&1 \
    && ./obj_dir/spu32_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q "^TB PASSED$" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed, see sim.log"; exit 1; }

//--- spu32_core.f
logic/wb8_bus_pkg.sv
logic/rv32_isa_pkg.sv
logic/rv_alu.sv
logic/rv_decoder.sv
logic/rv_regfile.sv
logic/wb8_byte_master.sv
logic/rv_sequencer.sv
logic/spu32_core.sv
test/spu32_core_tb.sv

//--- test/spu32_core_tb.sv
`timescale 1ns/1ps

module spu32_core_tb;

    localparam logic [31:0] reset_vector = 32'h0;
    // store records start at this trace word
    localparam int rec_base = 64;
    localparam logic [31:0] done_addr = 32'h0000_0FFC;

    logic        clk;
    logic        reset;
    logic        ack;
    logic        stall;
    logic [7:0]  rdata;
    logic [31:0] adr;
    logic [7:0]  wdata;
    logic        cyc;
    logic        stb;
    logic        we;

    logic [31:0] trace [0:127];
    logic [7:0]  mem [0:4095];
    integer      seed;
    int          checks;
    int          errors;
    int          rec_idx;
    bit          finished;
    bit          timed_out;

    spu32_core #(
        .reset_vector (reset_vector)
    ) u_spu32_core (
        .clk   (clk),
        .reset (reset),
        .ack   (ack),
        .stall (stall),
        .rdata (rdata),
        .adr   (adr),
        .wdata (wdata),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we)
    );

    always #20 clk = ~clk;

    task automatic check(input bit ok, input string what);
        checks++;
        assert (ok) $display("[PASS] %0t ns: %s", $time, what);
        else begin
            $display("[FAIL] %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    // silent unless the bus rule breaks
    task automatic protocol(input bit ok, input string what);
        assert (ok) else begin
            $display("[FAIL] %0t ns: bus protocol, %s", $time, what);
            errors++;
        end
    endtask

    task automatic compare_store(input logic [31:0] addr, input logic [31:0] val,
                                 input int size);
        logic [31:0] exp_addr;
        logic [31:0] exp_val;
        logic [31:0] exp_size;
        exp_addr = trace[rec_base + 3 * rec_idx];
        exp_val  = trace[rec_base + 3 * rec_idx + 1];
        exp_size = trace[rec_base + 3 * rec_idx + 2];
        if (exp_size == 0) begin
            check(1'b0, $sformatf("unexpected store to %h value %h", addr, val));
        end else begin
            check(addr == exp_addr && val == exp_val && size == exp_size,
                  $sformatf("store %0d at %h value %h size %0d, expected %h %h %0d",
                            rec_idx, addr, val, size, exp_addr, exp_val, exp_size));
            rec_idx++;
        end
        if (addr == done_addr) begin
            finished = 1'b1;
        end
    endtask

    // memory side of the bus, one byte cycle per pass
    initial begin : bus_model
        int          n;
        int          d;
        int          nbytes;
        bit          first_strobe;
        logic [31:0] a0;
        logic        w0;
        logic [7:0]  d0;
        logic [31:0] t_addr;
        logic [31:0] t_val;
        logic        t_we;
        first_strobe = 1'b1;
        nbytes       = 0;
        t_addr       = '0;
        t_val        = '0;
        t_we         = 1'b0;
        n            = 0;
        while (reset !== 1'b0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (reset !== 1'b0) begin
            $display("timeout: reset still asserted after 20 cycles");
            timed_out = 1'b1;
        end
        while (!timed_out && !finished) begin
            n = 0;
            while (!stb && n < 100) begin
                @(negedge clk);
                n++;
            end
            if (!stb) begin
                $display("timeout: no bus strobe within 100 cycles");
                timed_out = 1'b1;
            end else begin
                a0 = adr;
                w0 = we;
                d0 = wdata;
                if (first_strobe) begin
                    check(a0 == reset_vector && !w0, "first fetch reads the reset vector");
                    first_strobe = 1'b0;
                end
                if (nbytes == 0) begin
                    t_addr = a0;
                    t_we   = w0;
                    t_val  = '0;
                end else begin
                    protocol(a0 == t_addr + nbytes && w0 == t_we, "byte address not in sequence");
                end
                protocol(cyc, "stb without cyc");
                d = $unsigned($random(seed)) % 4;
                stall = (d != 0);
                repeat (d) begin
                    @(negedge clk);
                    protocol(stb && adr == a0 && we == w0 && wdata == d0,
                             "strobe fields changed under stall");
                end
                stall = 1'b0;
                // accepted on the rising edge in between
                @(negedge clk);
                protocol(!stb, "stb still high after acceptance");
                if (w0) begin
                    mem[a0[11:0]] = d0;
                    t_val[8 * nbytes +: 8] = d0;
                end
                d = $unsigned($random(seed)) % 4;
                repeat (d) begin
                    @(negedge clk);
                    protocol(cyc && !stb, "strobe or cyc changed while waiting for the ack");
                end
                ack   = 1'b1;
                rdata = mem[a0[11:0]];
                @(negedge clk);
                ack = 1'b0;
                nbytes++;
                if (!cyc) begin
                    if (!t_we && t_addr < 32'h400) begin
                        protocol(nbytes == 4, "word fetch is not four bytes");
                    end
                    if (t_we) begin
                        compare_store(t_addr, t_val, nbytes);
                    end
                    nbytes = 0;
                end else begin
                    protocol(nbytes < 4, "more than four bytes in one cycle");
                end
            end
        end
    end

    initial begin
        int n;
        bit quiet;
        clk       = 1'b0;
        reset     = 1'b1;
        ack       = 1'b0;
        stall     = 1'b0;
        rdata     = '0;
        seed      = 73032;
        checks    = 0;
        errors    = 0;
        rec_idx   = 0;
        finished  = 1'b0;
        timed_out = 1'b0;
        for (int i = 0; i < 4096; i++) begin
            mem[i] = '0;
        end
        for (int i = 0; i < 128; i++) begin
            trace[i] = '0;
        end
        $readmemh("test/spu32_trace.txt", trace);
        // program words, little endian
        for (int w = 0; w < rec_base; w++) begin
            for (int k = 0; k < 4; k++) begin
                mem[4 * w + k] = trace[w][8 * k +: 8];
            end
        end
        quiet = 1'b1;
        repeat (3) begin
            @(negedge clk);
            quiet = quiet && cyc === 1'b0 && stb === 1'b0;
        end
        check(quiet, "cyc and stb low during reset");
        reset = 1'b0;
        n = 0;
        while (!finished && !timed_out && n < 20000) begin
            @(negedge clk);
            n++;
        end
        if (!finished && !timed_out) begin
            $display("timeout: program did not reach the done store in 20000 cycles");
            timed_out = 1'b1;
        end
        assert (!finished || trace[rec_base + 3 * rec_idx + 2] == 0) else begin
            $display("store records left over after the done store");
            errors++;
        end
        $display("checks %0d, failures %0d, records consumed %0d", checks, errors, rec_idx);
        if (errors == 0 && finished && !timed_out) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- test/spu32_trace.txt
// words 0x00 to 0x3f: program, one instruction word per line from address 0
// words 0x40 on: store records, columns are address, value, size in bytes; size 0 ends
@0
123450B7
07F00113
FFD00193
00208233
40402023
403102B3
40502223
4011D313
003133B3
0021A433
007113B3
0083E3B3
0063C3B3
40702423
00001497
40902623
40400503
40404583
40801603
40805683
40A00823
40C01923
40B02A23
40D02C23
41002703
40E02E23
00310463
42202023
0021C463
42302223
0021E463
0021F463
42002223
008007EF
42002423
42F02223
09C00813
004808E7
42002623
42002623
43102423
0021D463
00311463
42002623
000012B7
FE42AE23
0000006F
@40
00000400 1234507F 00000004
00000404 00000082 00000004
00000408 FFFFFF01 00000004
0000040C 00001038 00000004
00000410 00000082 00000001
00000412 0000FF01 00000002
00000414 00000082 00000004
00000418 0000FF01 00000004
0000041C FF010082 00000004
00000420 0000007F 00000004
00000424 00000088 00000004
00000428 00000098 00000004
00000FFC 1234507F 00000004
00000000 00000000 00000000
